// File: rtl/atc_pkg.sv
// Shared definitions for the two-runway tower controller
// Message field widths, buffer depths and runway count
// Message type, decoded command and reply kind enums

package atc_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Message word layout
  ////////////////////////////////////////////////////////////////////////////

  localparam int PLANE_ID_W = 4;
  localparam int TYPE_W     = 3;
  localparam int ACTION_W   = 2;

  // Plane id, then type, then action
  localparam int MSG_W = PLANE_ID_W + TYPE_W + ACTION_W;

  ////////////////////////////////////////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////////////////////////////////////////

  // Runway 0 is the preferred one
  localparam int NUM_RUNWAYS = 2;

  localparam int REQ_DEPTH     = 4;
  localparam int PLANE_Q_DEPTH = 4;
  localparam int REPLY_DEPTH   = 4;

  ////////////////////////////////////////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////////////////////////////////////////

  // Inbound types sit low, outbound types have bit 2 set
  typedef enum logic [TYPE_W-1:0] {
    T_REQUEST   = 3'd0,
    T_DECLARE   = 3'd1,
    T_CLEAR     = 3'd4,
    T_HOLD      = 3'd5,
    T_SAY_AGAIN = 3'd6,
    T_DIVERT    = 3'd7
  } msg_type_t;

  typedef enum logic [1:0] {
    CMD_TAKEOFF,
    CMD_LANDING,
    CMD_DECLARE,
    CMD_INVALID
  } cmd_t;

  typedef enum logic [1:0] {
    R_CLEAR,
    R_HOLD,
    R_SAY_AGAIN,
    R_DIVERT
  } reply_kind_t;

endpackage

// File: rtl/atc_fifo.sv
// Generic circular FIFO with a count register
// Head word is presented combinationally

`timescale 1ns/1ns

module atc_fifo #(
  parameter int WIDTH = 9,
  parameter int DEPTH = 4
) (
  input  logic             clock,
  input  logic             reset_n,
  input  logic [WIDTH-1:0] data_in,
  input  logic             write,
  input  logic             read,
  output logic [WIDTH-1:0] data_out,
  output logic             full,
  output logic             empty
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_write;
  logic             do_read;

  assign empty    = (count == '0);
  assign full     = (count == CNT_W'(DEPTH));
  assign data_out = mem[rd_ptr];

  // A full buffer still takes a word when the head leaves in the same cycle
  assign do_read  = read && !empty;
  assign do_write = write && (!full || do_read);

  always_ff @(posedge clock) begin
    if (do_write) begin
      mem[wr_ptr] <= data_in;
    end
  end

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_write) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_read) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (do_write && !do_read) begin
        count <= count + 1'b1;
      end else if (do_read && !do_write) begin
        count <= count - 1'b1;
      end
    end
  end

  // Every user pops only behind its own non-empty check
  read_not_empty: assert property (@(posedge clock) disable iff (!reset_n)
    read |-> !empty);

endmodule

// File: rtl/request_decoder.sv
// Request buffer for incoming message words
// Splits the head word into plane, runway and decoded command

`timescale 1ns/1ns

module request_decoder import atc_pkg::*; (
  input  logic                  clock,
  input  logic                  reset_n,
  input  logic                  request_valid,
  input  logic [MSG_W-1:0]      request_data,
  output logic                  busy,
  output logic                  cmd_valid,
  output cmd_t                  cmd,
  output logic [PLANE_ID_W-1:0] cmd_plane,
  output logic                  cmd_runway,
  input  logic                  cmd_taken
);

  logic [MSG_W-1:0]    head;
  logic                req_empty;
  msg_type_t           head_type;
  logic [ACTION_W-1:0] head_action;

  atc_fifo #(
    .WIDTH (MSG_W),
    .DEPTH (REQ_DEPTH)
  ) u_req_fifo (
    .clock    (clock),
    .reset_n  (reset_n),
    .data_in  (request_data),
    .write    (request_valid),
    .read     (cmd_taken),
    .data_out (head),
    .full     (busy),
    .empty    (req_empty)
  );

  assign cmd_valid = !req_empty;

  // Head word fields
  assign cmd_plane   = head[MSG_W-1 -: PLANE_ID_W];
  assign head_type   = msg_type_t'(head[ACTION_W +: TYPE_W]);
  assign head_action = head[ACTION_W-1:0];

  // Declarations name the runway in action bit 0
  assign cmd_runway = head_action[0];

  always_comb begin
    cmd = CMD_INVALID;
    case (head_type)
      T_REQUEST: begin
        // Action bit 1 picks landing over takeoff
        cmd = head_action[1] ? CMD_LANDING : CMD_TAKEOFF;
      end
      T_DECLARE: begin
        cmd = CMD_DECLARE;
      end
      default: begin
        cmd = CMD_INVALID;
      end
    endcase
  end

endmodule

// File: rtl/runway_manager.sv
// Runway lock table
// One active bit and one owning plane id per runway

`timescale 1ns/1ns

module runway_manager import atc_pkg::*; (
  input  logic                   clock,
  input  logic                   reset_n,
  input  logic                   lock,
  input  logic                   unlock,
  input  logic                   runway_sel,
  input  logic [PLANE_ID_W-1:0]  lock_plane,
  output logic [NUM_RUNWAYS-1:0] runway_active
);

  logic [PLANE_ID_W-1:0] owner [NUM_RUNWAYS];

  // Owner of each runway, recorded on lock
  always_ff @(posedge clock) begin
    if (lock) begin
      owner[runway_sel] <= lock_plane;
    end
  end

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      runway_active <= '0;
    end else if (lock) begin
      runway_active[runway_sel] <= 1'b1;
    end else if (unlock) begin
      // Only the holder may release its runway
      if (owner[runway_sel] == lock_plane) begin
        runway_active[runway_sel] <= 1'b0;
      end
    end
  end

  // Controller drives lock and unlock from different states
  lock_unlock_excl: assert property (@(posedge clock) disable iff (!reset_n)
    !(lock && unlock));

endmodule

// File: rtl/tower_controller.sv
// Tower scheduling FSM
// Takes decoded commands, keeps the takeoff and landing queues
// and clears queued planes onto free runways

`timescale 1ns/1ns

module tower_controller import atc_pkg::*; (
  input  logic                   clock,
  input  logic                   reset_n,
  // Decoder side
  input  logic                   cmd_valid,
  input  cmd_t                   cmd,
  input  logic [PLANE_ID_W-1:0]  cmd_plane,
  input  logic                   cmd_runway,
  output logic                   cmd_taken,
  // Runway side
  input  logic [NUM_RUNWAYS-1:0] runway_active,
  output logic                   lock,
  output logic                   unlock,
  output logic                   runway_sel,
  output logic [PLANE_ID_W-1:0]  lock_plane,
  // Reply side
  output logic                   reply_valid,
  output reply_kind_t            reply_kind,
  output logic [PLANE_ID_W-1:0]  reply_plane,
  output logic                   reply_runway,
  input  logic                   reply_accept
);

  typedef enum logic [2:0] {
    IDLE,
    INTERPRET,
    REPLY,
    CHECK_QUEUES,
    CLEAR,
    OFFER_CLEAR
  } state_t;

  state_t state;
  state_t next_state;

  // Command taken from the decoder
  cmd_t                  cur_cmd;
  logic [PLANE_ID_W-1:0] cur_plane;
  logic                  cur_runway;

  logic                  landing_turn;
  logic                  to_push, to_pop, to_full, to_empty;
  logic                  ld_push, ld_pop, ld_full, ld_empty;
  logic [PLANE_ID_W-1:0] to_head, ld_head;
  logic                  pick_landing;
  logic                  free_runway;
  reply_kind_t           interp_kind;

  ////////////////////////////////////////////////////////////////////////////
  // Aircraft queues
  ////////////////////////////////////////////////////////////////////////////

  atc_fifo #(
    .WIDTH (PLANE_ID_W),
    .DEPTH (PLANE_Q_DEPTH)
  ) u_takeoff_q (
    .clock    (clock),
    .reset_n  (reset_n),
    .data_in  (cur_plane),
    .write    (to_push),
    .read     (to_pop),
    .data_out (to_head),
    .full     (to_full),
    .empty    (to_empty)
  );

  atc_fifo #(
    .WIDTH (PLANE_ID_W),
    .DEPTH (PLANE_Q_DEPTH)
  ) u_landing_q (
    .clock    (clock),
    .reset_n  (reset_n),
    .data_in  (cur_plane),
    .write    (ld_push),
    .read     (ld_pop),
    .data_out (ld_head),
    .full     (ld_full),
    .empty    (ld_empty)
  );

  // Landing wins when it is its turn or takeoffs are empty
  assign pick_landing = !ld_empty && (to_empty || landing_turn);
  // Lowest free runway
  assign free_runway  = runway_active[0];

  ////////////////////////////////////////////////////////////////////////////
  // Next state and strobes
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    next_state  = state;
    cmd_taken   = 1'b0;
    to_push     = 1'b0;
    ld_push     = 1'b0;
    to_pop      = 1'b0;
    ld_pop      = 1'b0;
    lock        = 1'b0;
    unlock      = 1'b0;
    reply_valid = 1'b0;
    interp_kind = R_SAY_AGAIN;
    runway_sel  = (state == CLEAR) ? reply_runway : cur_runway;
    lock_plane  = (state == CLEAR) ? reply_plane : cur_plane;

    case (state)
      IDLE: begin
        if (cmd_valid) begin
          cmd_taken  = 1'b1;
          next_state = INTERPRET;
        end else begin
          next_state = CHECK_QUEUES;
        end
      end
      INTERPRET: begin
        next_state = REPLY;
        case (cur_cmd)
          CMD_TAKEOFF: begin
            to_push     = !to_full;
            interp_kind = to_full ? R_DIVERT : R_HOLD;
          end
          CMD_LANDING: begin
            ld_push     = !ld_full;
            interp_kind = ld_full ? R_DIVERT : R_HOLD;
          end
          CMD_DECLARE: begin
            unlock     = 1'b1;
            next_state = CHECK_QUEUES;
          end
          default: begin
            interp_kind = R_SAY_AGAIN;
          end
        endcase
      end
      REPLY: begin
        reply_valid = 1'b1;
        if (reply_accept) begin
          next_state = CHECK_QUEUES;
        end
      end
      CHECK_QUEUES: begin
        // A plane leaves its queue only when a runway can take it
        if (!(&runway_active) && !(to_empty && ld_empty)) begin
          ld_pop     = pick_landing;
          to_pop     = !pick_landing;
          next_state = CLEAR;
        end else begin
          next_state = IDLE;
        end
      end
      CLEAR: begin
        lock       = 1'b1;
        next_state = OFFER_CLEAR;
      end
      OFFER_CLEAR: begin
        reply_valid = 1'b1;
        if (reply_accept) begin
          next_state = IDLE;
        end
      end
      default: begin
        next_state = IDLE;
      end
    endcase
  end

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      state        <= IDLE;
      landing_turn <= 1'b1;
    end else begin
      state <= next_state;
      if (state == CLEAR) begin
        landing_turn <= ~landing_turn;
      end
    end
  end

  // Command and reply fields
  always_ff @(posedge clock) begin
    if (cmd_taken) begin
      cur_cmd    <= cmd;
      cur_plane  <= cmd_plane;
      cur_runway <= cmd_runway;
    end
    if (state == INTERPRET) begin
      reply_kind   <= interp_kind;
      reply_plane  <= cur_plane;
      reply_runway <= 1'b0;
    end else if (to_pop || ld_pop) begin
      reply_kind   <= R_CLEAR;
      reply_plane  <= pick_landing ? ld_head : to_head;
      reply_runway <= free_runway;
    end
  end

  // The chosen runway is still free when the lock lands
  lock_free_runway: assert property (@(posedge clock) disable iff (!reset_n)
    lock |-> !runway_active[runway_sel]);

  // A lock shows in the runway table one cycle later
  lock_takes_effect: assert property (@(posedge clock) disable iff (!reset_n)
    lock |=> runway_active[$past(runway_sel)]);

endmodule

// File: rtl/reply_unit.sv
// Reply word builder and reply queue
// Two-state send sequencer for the ready/send handshake

`timescale 1ns/1ns

module reply_unit import atc_pkg::*; (
  input  logic                  clock,
  input  logic                  reset_n,
  input  logic                  reply_valid,
  input  reply_kind_t           reply_kind,
  input  logic [PLANE_ID_W-1:0] reply_plane,
  input  logic                  reply_runway,
  output logic                  reply_accept,
  input  logic                  tx_ready,
  output logic [MSG_W-1:0]      reply_data,
  output logic                  reply_send
);

  typedef enum logic {
    WAIT,
    SEND
  } send_state_t;

  send_state_t         send_state;
  msg_type_t           out_type;
  logic [ACTION_W-1:0] out_action;
  logic [MSG_W-1:0]    reply_word;
  logic [MSG_W-1:0]    head_word;
  logic                q_full;
  logic                q_empty;
  logic                pop;

  ////////////////////////////////////////////////////////////////////////////
  // Reply word
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    out_action = '0;
    case (reply_kind)
      R_CLEAR: begin
        out_type   = T_CLEAR;
        out_action = {{(ACTION_W-1){1'b0}}, reply_runway};
      end
      R_HOLD:      out_type = T_HOLD;
      R_SAY_AGAIN: out_type = T_SAY_AGAIN;
      default:     out_type = T_DIVERT;
    endcase
  end

  assign reply_word   = {reply_plane, out_type, out_action};
  assign reply_accept = !q_full;

  atc_fifo #(
    .WIDTH (MSG_W),
    .DEPTH (REPLY_DEPTH)
  ) u_reply_fifo (
    .clock    (clock),
    .reset_n  (reset_n),
    .data_in  (reply_word),
    .write    (reply_valid && reply_accept),
    .read     (pop),
    .data_out (head_word),
    .full     (q_full),
    .empty    (q_empty)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Send sequencer
  ////////////////////////////////////////////////////////////////////////////

  // Pop only from WAIT, so sends are at least two cycles apart
  assign pop        = (send_state == WAIT) && tx_ready && !q_empty;
  assign reply_send = (send_state == SEND);

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      send_state <= WAIT;
    end else if (pop) begin
      send_state <= SEND;
    end else begin
      send_state <= WAIT;
    end
  end

  // Output word, held until the next pop
  always_ff @(posedge clock) begin
    if (pop) begin
      reply_data <= head_word;
    end
  end

endmodule

// File: rtl/atc_top.sv
// Tower controller top level
// Wires decoder, scheduling FSM, runway table and reply unit

`timescale 1ns/1ns

module atc_top import atc_pkg::*; (
  input  logic                   clock,
  input  logic                   reset_n,
  input  logic                   request_valid,
  input  logic [MSG_W-1:0]       request_data,
  output logic                   busy,
  input  logic                   tx_ready,
  output logic [MSG_W-1:0]       reply_data,
  output logic                   reply_send,
  output logic [NUM_RUNWAYS-1:0] runway_active
);

  // Decoder to controller
  logic                  cmd_valid;
  cmd_t                  cmd;
  logic [PLANE_ID_W-1:0] cmd_plane;
  logic                  cmd_runway;
  logic                  cmd_taken;

  // Controller to runway table
  logic                  lock;
  logic                  unlock;
  logic                  runway_sel;
  logic [PLANE_ID_W-1:0] lock_plane;

  // Controller to reply unit
  logic                  reply_valid;
  reply_kind_t           reply_kind;
  logic [PLANE_ID_W-1:0] reply_plane;
  logic                  reply_runway;
  logic                  reply_accept;

  request_decoder u_decoder (
    .clock         (clock),
    .reset_n       (reset_n),
    .request_valid (request_valid),
    .request_data  (request_data),
    .busy          (busy),
    .cmd_valid     (cmd_valid),
    .cmd           (cmd),
    .cmd_plane     (cmd_plane),
    .cmd_runway    (cmd_runway),
    .cmd_taken     (cmd_taken)
  );

  tower_controller u_controller (
    .clock         (clock),
    .reset_n       (reset_n),
    .cmd_valid     (cmd_valid),
    .cmd           (cmd),
    .cmd_plane     (cmd_plane),
    .cmd_runway    (cmd_runway),
    .cmd_taken     (cmd_taken),
    .runway_active (runway_active),
    .lock          (lock),
    .unlock        (unlock),
    .runway_sel    (runway_sel),
    .lock_plane    (lock_plane),
    .reply_valid   (reply_valid),
    .reply_kind    (reply_kind),
    .reply_plane   (reply_plane),
    .reply_runway  (reply_runway),
    .reply_accept  (reply_accept)
  );

  runway_manager u_runways (
    .clock         (clock),
    .reset_n       (reset_n),
    .lock          (lock),
    .unlock        (unlock),
    .runway_sel    (runway_sel),
    .lock_plane    (lock_plane),
    .runway_active (runway_active)
  );

  reply_unit u_reply (
    .clock         (clock),
    .reset_n       (reset_n),
    .reply_valid   (reply_valid),
    .reply_kind    (reply_kind),
    .reply_plane   (reply_plane),
    .reply_runway  (reply_runway),
    .reply_accept  (reply_accept),
    .tx_ready      (tx_ready),
    .reply_data    (reply_data),
    .reply_send    (reply_send)
  );

endmodule

// File: tests/atc_tb.sv
// Testbench for the two-runway tower controller
// Reference model of aircraft queues, runway owners and turn register
// Reply monitor with typed compare tasks, directed and random stimulus, watchdog

`timescale 1ns/1ns

module atc_tb import atc_pkg::*; ();

  localparam int DIRECTED_REQUESTS = 40;
  localparam int NUM_RANDOM        = 48;
  localparam int NUM_REQUESTS      = DIRECTED_REQUESTS + NUM_RANDOM;
  localparam int SETTLE_CYCLES     = 16;
  localparam int TIMEOUT_CYCLES    = NUM_REQUESTS * 200 + 1000;

  logic                   clock = 1'b0;
  logic                   reset_n;
  logic                   request_valid;
  logic [MSG_W-1:0]       request_data;
  logic                   busy;
  logic                   tx_ready;
  logic [MSG_W-1:0]       reply_data;
  logic                   reply_send;
  logic [NUM_RUNWAYS-1:0] runway_active;

  integer      seed;
  logic [31:0] rnd;

  // Reference model state
  logic [PLANE_ID_W-1:0]  m_takeoff_q [$];
  logic [PLANE_ID_W-1:0]  m_landing_q [$];
  logic [NUM_RUNWAYS-1:0] m_active;
  logic [PLANE_ID_W-1:0]  m_owner [NUM_RUNWAYS];
  logic                   m_landing_turn;

  // Replies still to arrive, oldest first
  logic [MSG_W-1:0] exp_q [$];
  logic [MSG_W-1:0] exp_word;

  int sends         = 0;
  int type_errors   = 0;
  int plane_errors  = 0;
  int action_errors = 0;
  int runway_errors = 0;
  int extra_errors  = 0;
  int other_errors  = 0;

  atc_top DUT (
    .clock         (clock),
    .reset_n       (reset_n),
    .request_valid (request_valid),
    .request_data  (request_data),
    .busy          (busy),
    .tx_ready      (tx_ready),
    .reply_data    (reply_data),
    .reply_send    (reply_send),
    .runway_active (runway_active)
  );

  always #20 clock = ~clock;

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [MSG_W-1:0] make_msg(input logic [PLANE_ID_W-1:0] plane,
                                                input logic [TYPE_W-1:0]     mtype,
                                                input logic [ACTION_W-1:0]   action);
    return {plane, mtype, action};
  endfunction

  function automatic void predict_replies(input logic [MSG_W-1:0] msg);
    logic [PLANE_ID_W-1:0] plane;
    logic [TYPE_W-1:0]     mtype;
    logic [ACTION_W-1:0]   action;
    logic                  rw;
    logic                  use_landing;
    plane  = msg[MSG_W-1 -: PLANE_ID_W];
    mtype  = msg[ACTION_W +: TYPE_W];
    action = msg[ACTION_W-1:0];
    if (mtype == T_REQUEST && action[1]) begin
      if (m_landing_q.size() == PLANE_Q_DEPTH) begin
        exp_q.push_back(make_msg(plane, T_DIVERT, 2'b00));
      end else begin
        m_landing_q.push_back(plane);
        exp_q.push_back(make_msg(plane, T_HOLD, 2'b00));
      end
    end else if (mtype == T_REQUEST) begin
      if (m_takeoff_q.size() == PLANE_Q_DEPTH) begin
        exp_q.push_back(make_msg(plane, T_DIVERT, 2'b00));
      end else begin
        m_takeoff_q.push_back(plane);
        exp_q.push_back(make_msg(plane, T_HOLD, 2'b00));
      end
    end else if (mtype == T_DECLARE) begin
      rw = action[0];
      // Silent, and only the holder frees its runway
      if (m_active[rw] && m_owner[rw] == plane) begin
        m_active[rw] = 1'b0;
      end
    end else begin
      exp_q.push_back(make_msg(plane, T_SAY_AGAIN, 2'b00));
    end
    // Queued planes go to the lowest free runway
    while (m_active != '1 && (m_takeoff_q.size() + m_landing_q.size()) > 0) begin
      use_landing = (m_landing_q.size() > 0) && (m_takeoff_q.size() == 0 || m_landing_turn);
      if (use_landing) begin
        plane = m_landing_q.pop_front();
      end else begin
        plane = m_takeoff_q.pop_front();
      end
      rw = 1'b0;
      for (int r = NUM_RUNWAYS - 1; r >= 0; r--) begin
        if (!m_active[r]) begin
          rw = r[0];
        end
      end
      m_active[rw]   = 1'b1;
      m_owner[rw]    = plane;
      m_landing_turn = !m_landing_turn;
      exp_q.push_back(make_msg(plane, T_CLEAR, {1'b0, rw}));
    end
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_type(input msg_type_t got, input msg_type_t expected);
    if (got !== expected) begin
      type_errors++;
      $display("[ERROR] %0t ns: reply type %0d %s, expected %0d %s",
               $time, got, got.name(), expected, expected.name());
    end
  endtask

  task automatic check_plane(input logic [PLANE_ID_W-1:0] got,
                             input logic [PLANE_ID_W-1:0] expected);
    if (got !== expected) begin
      plane_errors++;
      $display("[ERROR] %0t ns: reply plane %0d, expected %0d", $time, got, expected);
    end
  endtask

  task automatic check_action(input logic [ACTION_W-1:0] got,
                              input logic [ACTION_W-1:0] expected);
    if (got !== expected) begin
      action_errors++;
      $display("[ERROR] %0t ns: reply action %b, expected %b", $time, got, expected);
    end
  endtask

  task automatic check_runways(input logic [NUM_RUNWAYS-1:0] got,
                               input logic [NUM_RUNWAYS-1:0] expected);
    if (got !== expected) begin
      runway_errors++;
      $display("[ERROR] %0t ns: runway_active %b, expected %b", $time, got, expected);
    end
  endtask

  task automatic compare_reply(input logic [MSG_W-1:0] got, input logic [MSG_W-1:0] expected);
    check_type(msg_type_t'(got[ACTION_W +: TYPE_W]), msg_type_t'(expected[ACTION_W +: TYPE_W]));
    check_plane(got[MSG_W-1 -: PLANE_ID_W], expected[MSG_W-1 -: PLANE_ID_W]);
    check_action(got[ACTION_W-1:0], expected[ACTION_W-1:0]);
  endtask

  // Reply monitor, sampled away from the driving edge
  always @(negedge clock) begin
    if (reset_n && reply_send) begin
      sends++;
      if (exp_q.size() == 0) begin
        extra_errors++;
        $display("[ERROR] %0t ns: reply %h arrived with none expected", $time, reply_data);
      end else begin
        exp_word = exp_q.pop_front();
        compare_reply(reply_data, exp_word);
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [PLANE_ID_W-1:0] random_plane();
    rnd = $random(seed);
    return rnd[PLANE_ID_W-1:0];
  endfunction

  task automatic send_message(input logic [MSG_W-1:0] msg);
    predict_replies(msg);
    @(posedge clock);
    request_valid <= 1'b1;
    request_data  <= msg;
    @(posedge clock);
    request_valid <= 1'b0;
  endtask

  // Drain every predicted reply, then a quiet window for stray ones
  task automatic wait_replies();
    while (exp_q.size() != 0) begin
      @(posedge clock);
    end
    repeat (SETTLE_CYCLES) @(negedge clock);
    check_runways(runway_active, m_active);
  endtask

  task automatic exchange(input logic [MSG_W-1:0] msg);
    send_message(msg);
    wait_replies();
  endtask

  initial begin
    logic [TYPE_W-1:0] t;
    logic              rw;
    int                sends_before;
    seed           = 32'h943d_3130;
    reset_n        = 1'b0;
    request_valid  = 1'b0;
    request_data   = '0;
    tx_ready       = 1'b1;
    m_active       = '0;
    m_landing_turn = 1'b1;
    repeat (3) @(posedge clock);
    reset_n <= 1'b1;
    @(negedge clock);
    if (busy !== 1'b0 || reply_send !== 1'b0) begin
      other_errors++;
      $display("[ERROR] %0t ns: busy %b, reply_send %b after reset, expected both low",
               $time, busy, reply_send);
    end
    check_runways(runway_active, '0);

    // Hold, then clear on runway 0
    exchange(make_msg(random_plane(), T_REQUEST, 2'b00));
    // Runway 1 for the next plane, then a third waits for a release
    exchange(make_msg(random_plane(), T_REQUEST, 2'b10));
    exchange(make_msg(random_plane(), T_REQUEST, 2'b00));
    exchange(make_msg(m_owner[0], T_DECLARE, 2'b00));
    // Release attempt by a plane that does not hold runway 1
    exchange(make_msg(m_owner[1] + 4'd1, T_DECLARE, 2'b01));

    // Unknown types, emergency included
    for (int i = 2; i < 8; i++) begin
      rnd = $random(seed);
      exchange(make_msg(random_plane(), TYPE_W'(i), rnd[9:8]));
    end

    // One more clearance brings the turn back to landing
    exchange(make_msg(m_owner[0], T_DECLARE, 2'b00));
    exchange(make_msg(random_plane(), T_REQUEST, 2'b00));

    // Overfill the takeoff queue, then release runways one at a time
    for (int i = 0; i < PLANE_Q_DEPTH + 1; i++) begin
      exchange(make_msg(random_plane(), T_REQUEST, 2'b00));
    end
    exchange(make_msg(random_plane(), T_REQUEST, 2'b10));
    exchange(make_msg(random_plane(), T_REQUEST, 2'b10));
    for (int i = 0; i < 6; i++) begin
      rw = i[0];
      exchange(make_msg(m_owner[rw], T_DECLARE, {1'b0, rw}));
    end

    // Burst with the transmitter stalled
    @(posedge clock);
    tx_ready <= 1'b0;
    sends_before = sends;
    for (int i = 0; i < 6; i++) begin
      if (i[0]) begin
        send_message(make_msg(random_plane(), T_REQUEST, 2'b00));
      end else begin
        send_message(make_msg(random_plane(), 3'd2, 2'b00));
      end
    end
    repeat (40) @(posedge clock);
    if (sends != sends_before) begin
      other_errors++;
      $display("[ERROR] %0t ns: %0d reply_send pulses while tx_ready was low, expected 0",
               $time, sends - sends_before);
    end
    tx_ready <= 1'b1;
    wait_replies();
    for (int i = 0; i < 2; i++) begin
      rw = i[0];
      exchange(make_msg(m_owner[rw], T_DECLARE, {1'b0, rw}));
    end

    // Random traffic
    for (int i = 0; i < NUM_RANDOM; i++) begin
      rnd = $random(seed);
      case (rnd[1:0])
        2'd1: begin
          rw = rnd[8];
          if (rnd[9]) begin
            exchange(make_msg(m_owner[rw], T_DECLARE, {1'b0, rw}));
          end else begin
            exchange(make_msg(rnd[13:10], T_DECLARE, {1'b0, rw}));
          end
        end
        2'd2: begin
          t = rnd[4:2];
          if (t < 3'd2) begin
            t = t + 3'd2;
          end
          exchange(make_msg(rnd[13:10], t, rnd[6:5]));
        end
        default: begin
          exchange(make_msg(rnd[13:10], T_REQUEST, rnd[6:5]));
        end
      endcase
    end

    if (exp_q.size() != 0) begin
      other_errors++;
      $display("%0d expected replies never arrived", exp_q.size());
    end
    $display("errors: type %0d, plane %0d, action %0d, runway %0d, extra %0d, other %0d",
             type_errors, plane_errors, action_errors, runway_errors, extra_errors,
             other_errors);
    if (type_errors + plane_errors + action_errors + runway_errors + extra_errors
        + other_errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clock);
    $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("test failed");
    $finish;
  end

endmodule

// File: sources.f
rtl/atc_pkg.sv
rtl/atc_fifo.sv
rtl/request_decoder.sv
rtl/runway_manager.sv
rtl/tower_controller.sv
rtl/reply_unit.sv
rtl/atc_top.sv
tests/atc_tb.sv

// File: Makefile
VERILATOR  ?= verilator
SIM_FLAGS  = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing
TOP        = atc_tb
FILELIST   = sources.f
OBJ_DIR    = obj_dir
LOG        = sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^test passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
